// File: exu_core.f
+incdir+include
logic/exu_isa_pkg.sv
logic/exu_pipe_pkg.sv
logic/exu_regfile.sv
logic/exu_bypass.sv
logic/exu_alu.sv
logic/exu_branch.sv
logic/exu_core.sv
test/exu_core_tb.sv

// File: include/exu_defines.svh
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

`default_nettype none

// data path and pc width
`define XLEN 32

// register index width
`define REG_ADDR_W 5

// architectural register count, x0 reads as zero
`define NUM_REGS 32

`default_nettype wire

`endif

// File: logic/exu_alu.sv
`include "exu_defines.svh"

`default_nettype none

module exu_alu import exu_isa_pkg::*; (
   input  wire alu_op_e           op,
   input  wire [`XLEN-1:0]        a,
   input  wire [`XLEN-1:0]        b,
   output logic [`XLEN-1:0]       result
);

   logic [4:0] shamt;
   logic       lt_s;
   logic       lt_u;

   // shifts only look at the low five bits
   assign shamt = b[4:0];

   assign lt_s = $signed(a) < $signed(b);
   assign lt_u = a < b;

   always_comb begin
      case (op)
         ALU_ADD: begin
            result = a + b;
         end
         ALU_SUB: begin
            result = a - b;
         end
         ALU_AND: begin
            result = a & b;
         end
         ALU_OR: begin
            result = a | b;
         end
         ALU_XOR: begin
            result = a ^ b;
         end
         ALU_SLT: begin
            result = {{(`XLEN-1){1'b0}}, lt_s};
         end
         ALU_SLTU: begin
            result = {{(`XLEN-1){1'b0}}, lt_u};
         end
         ALU_SLL: begin
            result = a << shamt;
         end
         ALU_SRL: begin
            result = a >> shamt;
         end
         ALU_SRA: begin
            result = $unsigned($signed(a) >>> shamt);
         end
         ALU_PASS_B: begin
            result = b;
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: logic/exu_branch.sv
`include "exu_defines.svh"

`default_nettype none

module exu_branch import exu_isa_pkg::*; (
   input  wire                    vld,
   input  wire bru_op_e           op,
   input  wire [`XLEN-1:0]        pc,
   input  wire [`XLEN-1:0]        a,
   input  wire [`XLEN-1:0]        b,
   input  wire [`XLEN-1:0]        offset,
   output logic                   taken,
   output logic [`XLEN-1:0]       target,
   output logic [`XLEN-1:0]       link
);

   logic             cond;
   logic [`XLEN-1:0] jalr_sum;

   always_comb begin
      case (op)
         BRU_BEQ: begin
            cond = (a == b);
         end
         BRU_BNE: begin
            cond = (a != b);
         end
         BRU_BLT: begin
            cond = $signed(a) < $signed(b);
         end
         BRU_BGE: begin
            cond = $signed(a) >= $signed(b);
         end
         BRU_BLTU: begin
            cond = a < b;
         end
         BRU_BGEU: begin
            cond = a >= b;
         end
         // jumps are unconditional
         BRU_JAL, BRU_JALR: begin
            cond = 1'b1;
         end
         default: begin
            cond = 1'b0;
         end
      endcase
   end

   assign taken = vld & cond;

   // jalr target is register relative with bit 0 cleared
   assign jalr_sum = a + offset;
   assign target   = (op == BRU_JALR) ? {jalr_sum[`XLEN-1:1], 1'b0} : pc + offset;

   assign link = pc + `XLEN'(4);

endmodule

`default_nettype wire

// File: logic/exu_bypass.sv
`include "exu_defines.svh"

`default_nettype none

module exu_bypass import exu_pipe_pkg::*; (
   input  wire [`REG_ADDR_W-1:0]  rs1,
   input  wire [`REG_ADDR_W-1:0]  rs2,
   input  wire [`XLEN-1:0]        rs1_data,
   input  wire [`XLEN-1:0]        rs2_data,
   input  wire exu_fwd_s          fwd_m,
   input  wire exu_fwd_s          fwd_w,
   output logic [`XLEN-1:0]       rs1_fwd,
   output logic [`XLEN-1:0]       rs2_fwd
);

   // youngest match wins, M is younger than W
   function automatic logic [`XLEN-1:0] pick(
      input logic [`REG_ADDR_W-1:0] rs,
      input logic [`XLEN-1:0]       rf_data,
      input exu_fwd_s               m,
      input exu_fwd_s               w
   );
      logic [`XLEN-1:0] val;
      val = rf_data;
      if (rs != '0) begin
         if (m.vld && (m.rd == rs)) begin
            val = m.data;
         end else if (w.vld && (w.rd == rs)) begin
            val = w.data;
         end
      end
      return val;
   endfunction

   assign rs1_fwd = pick(rs1, rs1_data, fwd_m, fwd_w);
   assign rs2_fwd = pick(rs2, rs2_data, fwd_m, fwd_w);

endmodule

`default_nettype wire

// File: logic/exu_core.sv
`include "exu_defines.svh"

`default_nettype none

module exu_core import exu_isa_pkg::*, exu_pipe_pkg::*; (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire exu_issue_s        issue,
   output exu_retire_s            retire,
   output logic                   redirect_taken,
   output logic [`XLEN-1:0]       redirect_target
);

   logic [`XLEN-1:0] rs1_data_d;
   logic [`XLEN-1:0] rs2_data_d;

   logic             e_vld;
   exu_issue_s       e_ins;
   logic [`XLEN-1:0] e_rs1_data;
   logic [`XLEN-1:0] e_rs2_data;

   logic [`XLEN-1:0] rs1_fwd;
   logic [`XLEN-1:0] rs2_fwd;
   logic [`XLEN-1:0] alu_a;
   logic [`XLEN-1:0] alu_b;
   logic [`XLEN-1:0] alu_res;

   logic             br_sel;
   logic             br_taken;
   logic [`XLEN-1:0] br_target;
   logic [`XLEN-1:0] br_link;

   exu_fwd_s         fwd_m;
   exu_fwd_s         fwd_w;
   exu_stage_s       m_d;
   exu_stage_s       m_q;
   exu_stage_s       w_q;

   exu_regfile exu_regfile_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .raddr1 (issue.rs1),
      .raddr2 (issue.rs2),
      .wr     (retire),
      .rdata1 (rs1_data_d),
      .rdata2 (rs2_data_d)
   );

   // E stage
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         e_vld <= 1'b0;
      end else begin
         e_vld <= issue.vld;
      end
   end

   always_ff @(posedge clk) begin
      e_ins      <= issue;
      e_rs1_data <= rs1_data_d;
      e_rs2_data <= rs2_data_d;
   end

   // a stage forwards only if it really writes rd
   always_comb begin
      fwd_m.vld  = m_q.vld & m_q.wen;
      fwd_m.rd   = m_q.rd;
      fwd_m.data = m_q.data;
      fwd_w.vld  = w_q.vld & w_q.wen;
      fwd_w.rd   = w_q.rd;
      fwd_w.data = w_q.data;
   end

   exu_bypass exu_bypass_i (
      .rs1      (e_ins.rs1),
      .rs2      (e_ins.rs2),
      .rs1_data (e_rs1_data),
      .rs2_data (e_rs2_data),
      .fwd_m    (fwd_m),
      .fwd_w    (fwd_w),
      .rs1_fwd  (rs1_fwd),
      .rs2_fwd  (rs2_fwd)
   );

   assign alu_a = e_ins.a_pc  ? e_ins.pc  : rs1_fwd;
   assign alu_b = e_ins.b_imm ? e_ins.imm : rs2_fwd;

   exu_alu exu_alu_i (
      .op     (e_ins.op.alu),
      .a      (alu_a),
      .b      (alu_b),
      .result (alu_res)
   );

   assign br_sel = (e_ins.unit == UNIT_BRU);

   exu_branch exu_branch_i (
      .vld    (e_vld & br_sel),
      .op     (e_ins.op.bru),
      .pc     (e_ins.pc),
      .a      (rs1_fwd),
      .b      (rs2_fwd),
      .offset (e_ins.offset),
      .taken  (br_taken),
      .target (br_target),
      .link   (br_link)
   );

   // result merge into M, branches write back the link value
   always_comb begin
      m_d.vld    = e_vld;
      m_d.wen    = e_ins.wen;
      m_d.rd     = e_ins.rd;
      m_d.data   = br_sel ? br_link : alu_res;
      m_d.taken  = br_taken;
      m_d.target = br_target;
   end

   // M and W stages
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         m_q <= '0;
         w_q <= '0;
      end else begin
         m_q <= m_d;
         w_q <= m_q;
      end
   end

   assign retire.vld  = w_q.vld & w_q.wen;
   assign retire.rd   = w_q.rd;
   assign retire.data = w_q.data;

   assign redirect_taken  = w_q.vld & w_q.taken;
   assign redirect_target = w_q.target;

endmodule

`default_nettype wire

// File: logic/exu_isa_pkg.sv
`include "exu_defines.svh"

`default_nettype none

package exu_isa_pkg;

   // execution unit select
   typedef enum logic {
      UNIT_ALU = 1'b0,
      UNIT_BRU = 1'b1
   } exu_unit_e;

   // alu operations, pass-b serves load-upper-immediate
   typedef enum logic [3:0] {
      ALU_ADD    = 4'd0,
      ALU_SUB    = 4'd1,
      ALU_AND    = 4'd2,
      ALU_OR     = 4'd3,
      ALU_XOR    = 4'd4,
      ALU_SLT    = 4'd5,
      ALU_SLTU   = 4'd6,
      ALU_SLL    = 4'd7,
      ALU_SRL    = 4'd8,
      ALU_SRA    = 4'd9,
      ALU_PASS_B = 4'd10
   } alu_op_e;

   // branch operations
   typedef enum logic [3:0] {
      BRU_BEQ  = 4'd0,
      BRU_BNE  = 4'd1,
      BRU_BLT  = 4'd2,
      BRU_BGE  = 4'd3,
      BRU_BLTU = 4'd4,
      BRU_BGEU = 4'd5,
      BRU_JAL  = 4'd6,
      BRU_JALR = 4'd7
   } bru_op_e;

   // one op word, read as alu or bru code depending on the unit field
   typedef union packed {
      alu_op_e alu;
      bru_op_e bru;
   } exu_op_u;

endpackage

`default_nettype wire

// File: logic/exu_pipe_pkg.sv
`include "exu_defines.svh"

`default_nettype none

package exu_pipe_pkg;

   // decoded instruction from the fetch/decode side
   typedef struct packed {
      logic                    vld;
      exu_isa_pkg::exu_unit_e  unit;
      exu_isa_pkg::exu_op_u    op;
      logic [`XLEN-1:0]        pc;
      logic [`REG_ADDR_W-1:0]  rs1;
      logic [`REG_ADDR_W-1:0]  rs2;
      logic [`REG_ADDR_W-1:0]  rd;
      logic                    wen;
      logic [`XLEN-1:0]        imm;
      logic                    a_pc;
      logic                    b_imm;
      logic [`XLEN-1:0]        offset;
   } exu_issue_s;

   // in-flight result visible to the bypass
   // vld here already means the stage writes rd
   typedef struct packed {
      logic                    vld;
      logic [`REG_ADDR_W-1:0]  rd;
      logic [`XLEN-1:0]        data;
   } exu_fwd_s;

   // M and W stage contents
   typedef struct packed {
      logic                    vld;
      logic                    wen;
      logic [`REG_ADDR_W-1:0]  rd;
      logic [`XLEN-1:0]        data;
      logic                    taken;
      logic [`XLEN-1:0]        target;
   } exu_stage_s;

   // writeback result, also the register file write port
   typedef struct packed {
      logic                    vld;
      logic [`REG_ADDR_W-1:0]  rd;
      logic [`XLEN-1:0]        data;
   } exu_retire_s;

endpackage

`default_nettype wire

// File: logic/exu_regfile.sv
`include "exu_defines.svh"

`default_nettype none

module exu_regfile import exu_pipe_pkg::*; (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire [`REG_ADDR_W-1:0]  raddr1,
   input  wire [`REG_ADDR_W-1:0]  raddr2,
   input  wire exu_retire_s       wr,
   output logic [`XLEN-1:0]       rdata1,
   output logic [`XLEN-1:0]       rdata2
);

   logic [`XLEN-1:0] regs [`NUM_REGS];
   logic             hit1;
   logic             hit2;

   // x0 is never written, so it keeps its reset value
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr.vld && (wr.rd != '0)) begin
         regs[wr.rd] <= wr.data;
      end
   end

   // write-through for a consumer three behind the producer
   assign hit1 = wr.vld && (wr.rd == raddr1);
   assign hit2 = wr.vld && (wr.rd == raddr2);

   assign rdata1 = (raddr1 == '0) ? '0 : (hit1 ? wr.data : regs[raddr1]);
   assign rdata2 = (raddr2 == '0) ? '0 : (hit2 ? wr.data : regs[raddr2]);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the exu_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
sim_bin=exu_core_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module exu_core_tb -f exu_core.f \
   --Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "all tests passed" "$log_file"; then
   exit 0
fi
echo "pass line not found in $log_file"
exit 1

// File: test/exu_core_tb.sv
`include "exu_defines.svh"

`default_nettype none

module exu_core_tb
   import exu_isa_pkg::*, exu_pipe_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int PERIOD     = 10;
   localparam int RAND_COUNT = 200;
   // per test cycle budget, random gaps add at most two cycles each
   localparam int TEST_CYCLES = 17 + 52 + 20 + 29 + 20 + RAND_COUNT * 3 + 5;

   // one expected writeback and redirect event
   typedef struct packed {
      logic                    rvld;
      logic [`REG_ADDR_W-1:0]  rd;
      logic [`XLEN-1:0]        data;
      logic                    taken;
      logic [`XLEN-1:0]        target;
   } expect_s;

   logic              clk;
   logic              rst_n;
   exu_issue_s        issue;
   exu_retire_s       retire;
   logic              redirect_taken;
   logic [`XLEN-1:0]  redirect_target;

   logic [`XLEN-1:0]  model_regs [`NUM_REGS];
   logic [`XLEN-1:0]  next_pc;
   expect_s           exp_issue;
   expect_s           exp_e;
   expect_s           exp_m;
   expect_s           exp_w;
   string             cur_test;
   int                errors;
   int                test_count;
   int                tests_bad;
   int                test_start_errors;
   int                seed;

   exu_core exu_core_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .issue           (issue),
      .retire          (retire),
      .redirect_taken  (redirect_taken),
      .redirect_target (redirect_target)
   );

   always #(PERIOD / 2) clk = ~clk;

   // expected events follow the same three edges as the pipeline
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         exp_e <= '0;
         exp_m <= '0;
         exp_w <= '0;
      end else begin
         exp_e <= exp_issue;
         exp_m <= exp_e;
         exp_w <= exp_m;
      end
   end

   reset_quiet: assert property (@(posedge clk) !rst_n |-> (!retire.vld && !redirect_taken))
      else begin
         errors++;
         $display("MISMATCH %s retire/redirect in reset expected 0/0 actual %0b/%0b",
                  cur_test, $sampled(retire.vld), $sampled(redirect_taken));
      end

   retire_valid: assert property (@(posedge clk) disable iff (!rst_n)
      retire.vld == exp_w.rvld)
      else begin
         errors++;
         $display("MISMATCH %s retire.vld expected %0b actual %0b",
                  cur_test, $sampled(exp_w.rvld), $sampled(retire.vld));
      end

   retire_value: assert property (@(posedge clk) disable iff (!rst_n)
      exp_w.rvld |-> (retire.rd == exp_w.rd && retire.data == exp_w.data))
      else begin
         errors++;
         $display("MISMATCH %s retire expected x%0d=%h actual x%0d=%h", cur_test,
                  $sampled(exp_w.rd), $sampled(exp_w.data),
                  $sampled(retire.rd), $sampled(retire.data));
      end

   redirect_flag: assert property (@(posedge clk) disable iff (!rst_n)
      redirect_taken == exp_w.taken)
      else begin
         errors++;
         $display("MISMATCH %s redirect_taken expected %0b actual %0b",
                  cur_test, $sampled(exp_w.taken), $sampled(redirect_taken));
      end

   redirect_addr: assert property (@(posedge clk) disable iff (!rst_n)
      exp_w.taken |-> redirect_target == exp_w.target)
      else begin
         errors++;
         $display("MISMATCH %s redirect_target expected %h actual %h",
                  cur_test, $sampled(exp_w.target), $sampled(redirect_target));
      end

   // two's complement compare from the sign bits
   function automatic logic signed_less(input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
      if (a[`XLEN-1] != b[`XLEN-1]) begin
         return a[`XLEN-1];
      end
      return a < b;
   endfunction

   function automatic logic [`XLEN-1:0] alu_result(input alu_op_e op,
                                                  input logic [`XLEN-1:0] a,
                                                  input logic [`XLEN-1:0] b);
      logic [2*`XLEN-1:0] sra_wide;
      sra_wide = {{`XLEN{a[`XLEN-1]}}, a} >> b[4:0];
      case (op)
         ALU_ADD:    return a + b;
         ALU_SUB:    return a + ~b + 1'b1;
         ALU_AND:    return a & b;
         ALU_OR:     return a | b;
         ALU_XOR:    return a ^ b;
         ALU_SLT:    return {{(`XLEN-1){1'b0}}, signed_less(a, b)};
         ALU_SLTU:   return {{(`XLEN-1){1'b0}}, a < b};
         ALU_SLL:    return a << b[4:0];
         ALU_SRL:    return a >> b[4:0];
         ALU_SRA:    return sra_wide[`XLEN-1:0];
         ALU_PASS_B: return b;
         default:    return '0;
      endcase
   endfunction

   function automatic logic branch_cond(input bru_op_e op,
                                        input logic [`XLEN-1:0] a,
                                        input logic [`XLEN-1:0] b);
      case (op)
         BRU_BEQ:  return a == b;
         BRU_BNE:  return a != b;
         BRU_BLT:  return signed_less(a, b);
         BRU_BGE:  return !signed_less(a, b);
         BRU_BLTU: return a < b;
         BRU_BGEU: return !(a < b);
         BRU_JAL:  return 1'b1;
         BRU_JALR: return 1'b1;
         default:  return 1'b0;
      endcase
   endfunction

   function automatic exu_issue_s alu_ins(input alu_op_e op, input int rd, input int rs1,
                                          input int rs2, input logic [`XLEN-1:0] imm,
                                          input int a_pc, input int b_imm);
      exu_issue_s ins;
      ins        = '0;
      ins.unit   = UNIT_ALU;
      ins.op.alu = op;
      ins.rd     = `REG_ADDR_W'(rd);
      ins.rs1    = `REG_ADDR_W'(rs1);
      ins.rs2    = `REG_ADDR_W'(rs2);
      ins.wen    = 1'b1;
      ins.imm    = imm;
      ins.a_pc   = (a_pc != 0);
      ins.b_imm  = (b_imm != 0);
      return ins;
   endfunction

   function automatic exu_issue_s bru_ins(input bru_op_e op, input int rd, input int rs1,
                                          input int rs2, input logic [`XLEN-1:0] offset);
      exu_issue_s ins;
      ins        = '0;
      ins.unit   = UNIT_BRU;
      ins.op.bru = op;
      ins.rd     = `REG_ADDR_W'(rd);
      ins.rs1    = `REG_ADDR_W'(rs1);
      ins.rs2    = `REG_ADDR_W'(rs2);
      ins.wen    = 1'b1;
      ins.offset = offset;
      return ins;
   endfunction

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
         issue     = '0;
         exp_issue = '0;
      end
   endtask

   // drives one instruction and updates the architectural model in program order
   task automatic issue_instr(input exu_issue_s ins);
      logic [`XLEN-1:0] a_src;
      logic [`XLEN-1:0] b_src;
      expect_s          e;
      @(posedge clk);
      #1;
      ins.vld = 1'b1;
      ins.pc  = next_pc;
      next_pc = next_pc + 4;
      a_src   = model_regs[ins.rs1];
      b_src   = model_regs[ins.rs2];
      e       = '0;
      e.rvld  = ins.wen;
      e.rd    = ins.rd;
      if (ins.unit == UNIT_ALU) begin
         e.data = alu_result(ins.op.alu, ins.a_pc ? ins.pc : a_src,
                             ins.b_imm ? ins.imm : b_src);
      end else begin
         e.data  = ins.pc + 4;
         e.taken = branch_cond(ins.op.bru, a_src, b_src);
         if (ins.op.bru == BRU_JALR) begin
            e.target = (a_src + ins.offset) & ~`XLEN'(1);
         end else begin
            e.target = ins.pc + ins.offset;
         end
      end
      if (ins.wen && ins.rd != '0) begin
         model_regs[ins.rd] = e.data;
      end
      issue     = ins;
      exp_issue = e;
   endtask

   task automatic start_test(input string name);
      cur_test          = name;
      test_start_errors = errors;
   endtask

   task automatic end_test();
      int n;
      // let the last instruction drain past W
      idle(5);
      n = errors - test_start_errors;
      test_count++;
      if (n != 0) begin
         tests_bad++;
      end
      $display("test %s finished with %0d errors", cur_test, n);
   endtask

   initial begin
      #(2 * TEST_CYCLES * PERIOD);
      $display("timeout: simulation ran past %0d cycles without finishing", 2 * TEST_CYCLES);
      $display("tests failed");
      $finish;
   end

   initial begin
      exu_issue_s ins;
      int         r_rd;
      int         r_rs1;
      int         r_rs2;
      int         r_op;
      int         r_flags;
      int         unit_pick;
      int         gap;
      clk        = 1'b0;
      rst_n      = 1'b1;
      issue      = '0;
      exp_issue  = '0;
      next_pc    = 32'h0000_1000;
      errors     = 0;
      test_count = 0;
      tests_bad  = 0;
      seed       = 32'h38acca2e;
      for (int i = 0; i < `NUM_REGS; i++) begin
         model_regs[i] = '0;
      end

      start_test("reset");
      #1;
      rst_n = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
      idle(4);
      end_test();

      start_test("alu_ops");
      issue_instr(alu_ins(ALU_PASS_B, 1, 0, 0, 32'h8000_1234, 0, 1));
      issue_instr(alu_ins(ALU_PASS_B, 2, 0, 0, 32'h0000_0005, 0, 1));
      issue_instr(alu_ins(ALU_PASS_B, 3, 0, 0, 32'hffff_fff9, 0, 1));
      for (int k = 0; k <= 10; k++) begin
         for (int c = 0; c < 4; c++) begin
            issue_instr(alu_ins(alu_op_e'(4'(k)), 10 + c, 1, (k % 2 == 0) ? 2 : 3,
                                32'h0000_0023 + k, c / 2, c % 2));
         end
      end
      end_test();

      // consumer distance 1, 2 and 3 hits M, W and the register file
      start_test("forwarding");
      for (int d = 1; d <= 3; d++) begin
         issue_instr(alu_ins(ALU_ADD, 5, 1, 0, 32'h100 * d, 0, 1));
         for (int f = 1; f < d; f++) begin
            issue_instr(alu_ins(ALU_XOR, 20 + f, 2, 3, 0, 0, 0));
         end
         issue_instr(alu_ins(ALU_ADD, 6, 5, 5, 0, 0, 0));
         issue_instr(alu_ins(ALU_SUB, 7, 6, 2, 0, 0, 0));
      end
      end_test();

      start_test("branches");
      for (int k = 0; k < 8; k++) begin
         issue_instr(bru_ins(bru_op_e'(4'(k)), 9, 2, 2, 32'h0000_0040));
         issue_instr(bru_ins(bru_op_e'(4'(k)), 9, 3, 2, 32'h0000_0021));
         issue_instr(bru_ins(bru_op_e'(4'(k)), 9, 2, 3, 32'hffff_ffe0));
      end
      end_test();

      start_test("reg_zero");
      issue_instr(alu_ins(ALU_PASS_B, 0, 0, 0, 32'hdead_beef, 0, 1));
      issue_instr(alu_ins(ALU_ADD, 11, 0, 0, 0, 0, 0));
      issue_instr(alu_ins(ALU_OR, 12, 1, 0, 0, 0, 0));
      issue_instr(alu_ins(ALU_ADD, 13, 0, 0, 0, 0, 0));
      ins     = alu_ins(ALU_PASS_B, 14, 0, 0, 32'h1357_9bdf, 0, 1);
      ins.wen = 1'b0;
      issue_instr(ins);
      issue_instr(alu_ins(ALU_ADD, 15, 14, 0, 0, 0, 0));
      idle(3);
      issue_instr(alu_ins(ALU_OR, 16, 14, 0, 0, 0, 0));
      end_test();

      // small register range keeps hazards frequent
      start_test("random");
      for (int n = 0; n < RAND_COUNT; n++) begin
         unit_pick = $unsigned($random(seed)) % 4;
         r_rd      = $unsigned($random(seed)) % 8;
         r_rs1     = $unsigned($random(seed)) % 8;
         r_rs2     = $unsigned($random(seed)) % 8;
         r_flags   = $unsigned($random(seed)) % 4;
         if (unit_pick == 0) begin
            r_op = $unsigned($random(seed)) % 8;
            ins  = bru_ins(bru_op_e'(4'(r_op)), r_rd, r_rs1, r_rs2, $random(seed));
         end else begin
            r_op = $unsigned($random(seed)) % 11;
            ins  = alu_ins(alu_op_e'(4'(r_op)), r_rd, r_rs1, r_rs2, $random(seed),
                           r_flags % 2, r_flags / 2);
         end
         ins.wen = ($unsigned($random(seed)) % 8) != 0;
         issue_instr(ins);
         gap = $unsigned($random(seed)) % 8;
         if (gap > 2) begin
            gap = 0;
         end
         idle(gap);
      end
      end_test();

      $display("summary: %0d tests run, %0d with errors, %0d check errors in total",
               test_count, tests_bad, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
